/* rtl/bus_pkg.sv */
`default_nettype none

package bus_pkg;

  // Nodes on the snooping fabric
  localparam int NUM_NODES = 4;

  typedef logic [$clog2(NUM_NODES)-1:0] node_id_t;

  // The home is the last node
  localparam node_id_t HOME_ID = node_id_t'(NUM_NODES - 1);

  // Request bus transactions
  typedef enum logic [1:0] {
    GETS,
    GETM,
    PUTM
  } req_tx_t;

  // Response bus message kinds
  typedef enum logic [1:0] {
    DATA,
    EXCLUSIVE,
    NODATA,
    NODATAE
  } resp_kind_t;

endpackage

`default_nettype wire

/* rtl/llc_pkg.sv */
`default_nettype none

package llc_pkg;

  // Line geometry of the home store
  localparam int NUM_LINES = 16;
  localparam int ADDR_BITS = $clog2(NUM_LINES);
  localparam int LINE_BITS = 64;

  typedef logic [ADDR_BITS-1:0] line_addr_t;
  typedef logic [LINE_BITS-1:0] line_t;

  // Home view of each line
  // D suffix waits for owner data and RD for the home's own response
  typedef enum logic [2:0] {
    I,
    S,
    EORM,
    ID,
    SD,
    EORMD,
    SRD,
    EORMRD
  } llc_state_t;

endpackage

`default_nettype wire

/* rtl/llc_line_store.sv */
`default_nettype none

module llc_line_store
  import llc_pkg::*;
(
  input  wire logic       clk,
  input  wire logic       rst,
  input  wire line_addr_t raddr,
  output line_t           rdata,
  input  wire logic       we,
  input  wire line_addr_t waddr,
  input  wire line_t      wdata
);

  line_t mem [NUM_LINES];

  // Read path is combinational so data is ready in the request cycle
  assign rdata = mem[raddr];

  always_ff @(posedge clk) begin
    if (rst) begin
      mem <= '{default: '0};
    end else if (we) begin
      mem[waddr] <= wdata;
    end
  end

endmodule

`default_nettype wire

/* rtl/resp_bus_arbiter.sv */
`default_nettype none

module resp_bus_arbiter
  import bus_pkg::*, llc_pkg::*;
(
  input  wire logic       clk,
  input  wire logic       rst,

  // Home requester
  input  wire logic       home_req,
  input  wire node_id_t   home_dest,
  input  wire resp_kind_t home_kind,
  input  wire line_addr_t home_addr,
  input  wire line_t      home_data,
  output logic            home_gnt,

  // Peer requester
  input  wire logic       peer_req,
  input  wire node_id_t   peer_source,
  input  wire node_id_t   peer_dest,
  input  wire logic       peer_mem_flag,
  input  wire resp_kind_t peer_kind,
  input  wire line_addr_t peer_addr,
  input  wire line_t      peer_data,
  output logic            peer_gnt,

  // Response bus
  output logic            resp_valid,
  output node_id_t        resp_source,
  output node_id_t        resp_dest,
  output logic            resp_mem_flag,
  output resp_kind_t      resp_kind,
  output line_addr_t      resp_addr,
  output line_t           resp_data
);

  // High when the home won the last granted cycle
  logic last_home;

  always_comb begin
    home_gnt = 1'b0;
    peer_gnt = 1'b0;
    if (home_req && peer_req) begin
      // Tie goes to whoever did not win last
      if (last_home) begin
        peer_gnt = 1'b1;
      end else begin
        home_gnt = 1'b1;
      end
    end else begin
      home_gnt = home_req;
      peer_gnt = peer_req;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      last_home <= 1'b0;
    end else if (home_gnt) begin
      last_home <= 1'b1;
    end else if (peer_gnt) begin
      last_home <= 1'b0;
    end
  end

  // Home messages never carry the memory flag
  assign resp_valid    = home_gnt | peer_gnt;
  assign resp_source   = home_gnt ? HOME_ID   : peer_source;
  assign resp_dest     = home_gnt ? home_dest : peer_dest;
  assign resp_mem_flag = home_gnt ? 1'b0      : peer_mem_flag;
  assign resp_kind     = home_gnt ? home_kind : peer_kind;
  assign resp_addr     = home_gnt ? home_addr : peer_addr;
  assign resp_data     = home_gnt ? home_data : peer_data;

  a_one_grant: assert property (@(posedge clk) disable iff (rst)
    !(home_gnt && peer_gnt));

  // Under steady contention the winner flips every cycle
  a_alternate: assert property (@(posedge clk) disable iff (rst)
    home_req && peer_req && home_gnt ##1 home_req && peer_req |-> peer_gnt);

endmodule

`default_nettype wire

/* rtl/llc_coherence.sv */
`default_nettype none

module llc_coherence
  import bus_pkg::*, llc_pkg::*;
(
  input  wire logic       clk,
  input  wire logic       rst,

  // Request bus
  input  wire logic       req_valid,
  input  wire req_tx_t    req_tx,
  input  wire node_id_t   req_source,
  input  wire line_addr_t req_addr,

  // Response bus as seen by every node
  input  wire logic       resp_valid,
  input  wire node_id_t   resp_source,
  input  wire logic       resp_mem_flag,
  input  wire resp_kind_t resp_kind,
  input  wire line_addr_t resp_addr,
  input  wire line_t      resp_data,

  // Home requester toward the arbiter
  output logic            home_req,
  output node_id_t        home_dest,
  output resp_kind_t      home_kind,
  output line_addr_t      home_addr,
  output line_t           home_data,
  input  wire logic       home_gnt,

  // Line store
  input  wire line_t      store_rdata,
  output logic            store_we,
  output line_addr_t      store_waddr,
  output line_t           store_wdata
);

  llc_state_t line_state      [NUM_LINES];
  llc_state_t line_state_next [NUM_LINES];

  logic       resp_start;
  resp_kind_t resp_kind_next;
  logic       own_seen;
  logic       wb_data;
  logic       no_data;

  assign own_seen = resp_valid && (resp_source == HOME_ID);
  assign wb_data  = resp_valid && resp_mem_flag && (resp_kind == DATA);
  assign no_data  = resp_valid && ((resp_kind == NODATA) || (resp_kind == NODATAE));

  // Write-backs always land at the address on the bus
  assign store_waddr = resp_addr;
  assign store_wdata = resp_data;

  always_comb begin
    line_state_next = line_state;
    resp_start      = 1'b0;
    resp_kind_next  = DATA;
    store_we        = 1'b0;

    if (req_valid) begin
      case (line_state[req_addr])
        I: begin
          case (req_tx)
            GETS: begin
              resp_start                = 1'b1;
              resp_kind_next            = EXCLUSIVE;
              line_state_next[req_addr] = EORMRD;
            end
            GETM: begin
              resp_start                = 1'b1;
              line_state_next[req_addr] = EORMRD;
            end
            PUTM: line_state_next[req_addr] = ID;
            default: begin
            end
          endcase
        end
        S: begin
          case (req_tx)
            GETS: begin
              resp_start                = 1'b1;
              line_state_next[req_addr] = SRD;
            end
            GETM: begin
              resp_start                = 1'b1;
              line_state_next[req_addr] = EORMRD;
            end
            PUTM: line_state_next[req_addr] = SD;
            default: begin
            end
          endcase
        end
        EORM: begin
          // Owner answers and the home only tracks where the data goes
          if (req_tx == GETS) begin
            line_state_next[req_addr] = SD;
          end else if (req_tx == PUTM) begin
            line_state_next[req_addr] = EORMD;
          end
        end
        default: begin
        end
      endcase
    end else if (own_seen) begin
      // Own response is on the bus so the line commits
      case (line_state[resp_addr])
        SRD:     line_state_next[resp_addr] = S;
        EORMRD:  line_state_next[resp_addr] = EORM;
        default: begin
        end
      endcase
    end else if (resp_valid) begin
      case (line_state[resp_addr])
        ID: begin
          if (wb_data) begin
            store_we                   = 1'b1;
            line_state_next[resp_addr] = I;
          end else if (no_data) begin
            line_state_next[resp_addr] = I;
          end
        end
        SD: begin
          if (wb_data) begin
            store_we                   = 1'b1;
            line_state_next[resp_addr] = S;
          end else if (no_data) begin
            line_state_next[resp_addr] = S;
          end
        end
        EORMD: begin
          if (wb_data) begin
            store_we                   = 1'b1;
            line_state_next[resp_addr] = I;
          end else if (resp_kind == NODATA) begin
            // Owner keeps the line
            line_state_next[resp_addr] = EORM;
          end else if (resp_kind == NODATAE) begin
            line_state_next[resp_addr] = I;
          end
        end
        default: begin
        end
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      line_state <= '{default: I};
      home_req   <= 1'b0;
    end else begin
      line_state <= line_state_next;
      if (resp_start) begin
        home_req <= 1'b1;
      end else if (own_seen) begin
        home_req <= 1'b0;
      end
    end
  end

  // Response fields captured when the request is seen
  always_ff @(posedge clk) begin
    if (resp_start) begin
      home_dest <= req_source;
      home_kind <= resp_kind_next;
      home_addr <= req_addr;
      home_data <= store_rdata;
    end
  end

  // Request and response buses are never active together
  a_bus_exclusive: assert property (@(posedge clk) disable iff (rst)
    !(req_valid && resp_valid));

  a_req_hold: assert property (@(posedge clk) disable iff (rst)
    home_req && !home_gnt |=> home_req);

  a_fields_stable: assert property (@(posedge clk) disable iff (rst)
    home_req && !home_gnt |=> $stable({home_dest, home_kind, home_addr, home_data}));

endmodule

`default_nettype wire

/* rtl/llc_home_top.sv */
`default_nettype none

module llc_home_top
  import bus_pkg::*, llc_pkg::*;
(
  input  wire logic       clk,
  input  wire logic       rst,

  // Request bus
  input  wire logic       req_valid,
  input  wire req_tx_t    req_tx,
  input  wire node_id_t   req_source,
  input  wire line_addr_t req_addr,

  // Peer requester
  input  wire logic       peer_req,
  input  wire node_id_t   peer_source,
  input  wire node_id_t   peer_dest,
  input  wire logic       peer_mem_flag,
  input  wire resp_kind_t peer_kind,
  input  wire line_addr_t peer_addr,
  input  wire line_t      peer_data,
  output logic            peer_gnt,

  // Response bus
  output logic            resp_valid,
  output node_id_t        resp_source,
  output node_id_t        resp_dest,
  output logic            resp_mem_flag,
  output resp_kind_t      resp_kind,
  output line_addr_t      resp_addr,
  output line_t           resp_data
);

  logic       home_req;
  logic       home_gnt;
  node_id_t   home_dest;
  resp_kind_t home_kind;
  line_addr_t home_addr;
  line_t      home_data;

  line_t      store_rdata;
  logic       store_we;
  line_addr_t store_waddr;
  line_t      store_wdata;

  llc_coherence u_llc_coherence (
    .clk           (clk),
    .rst           (rst),
    .req_valid     (req_valid),
    .req_tx        (req_tx),
    .req_source    (req_source),
    .req_addr      (req_addr),
    .resp_valid    (resp_valid),
    .resp_source   (resp_source),
    .resp_mem_flag (resp_mem_flag),
    .resp_kind     (resp_kind),
    .resp_addr     (resp_addr),
    .resp_data     (resp_data),
    .home_req      (home_req),
    .home_dest     (home_dest),
    .home_kind     (home_kind),
    .home_addr     (home_addr),
    .home_data     (home_data),
    .home_gnt      (home_gnt),
    .store_rdata   (store_rdata),
    .store_we      (store_we),
    .store_waddr   (store_waddr),
    .store_wdata   (store_wdata)
  );

  // Store is read at the request address
  llc_line_store u_llc_line_store (
    .clk   (clk),
    .rst   (rst),
    .raddr (req_addr),
    .rdata (store_rdata),
    .we    (store_we),
    .waddr (store_waddr),
    .wdata (store_wdata)
  );

  resp_bus_arbiter u_resp_bus_arbiter (
    .clk           (clk),
    .rst           (rst),
    .home_req      (home_req),
    .home_dest     (home_dest),
    .home_kind     (home_kind),
    .home_addr     (home_addr),
    .home_data     (home_data),
    .home_gnt      (home_gnt),
    .peer_req      (peer_req),
    .peer_source   (peer_source),
    .peer_dest     (peer_dest),
    .peer_mem_flag (peer_mem_flag),
    .peer_kind     (peer_kind),
    .peer_addr     (peer_addr),
    .peer_data     (peer_data),
    .peer_gnt      (peer_gnt),
    .resp_valid    (resp_valid),
    .resp_source   (resp_source),
    .resp_dest     (resp_dest),
    .resp_mem_flag (resp_mem_flag),
    .resp_kind     (resp_kind),
    .resp_addr     (resp_addr),
    .resp_data     (resp_data)
  );

endmodule

`default_nettype wire

/* sim/llc_home_model.svh */
`ifndef LLC_HOME_MODEL_SVH
`define LLC_HOME_MODEL_SVH

// Expected coherence state and data of every home line
llc_state_t model_state [NUM_LINES];
line_t      model_data  [NUM_LINES];

function automatic void clear_lines();
  for (int k = 0; k < NUM_LINES; k++) begin
    model_state[k] = I;
    model_data[k]  = '0;
  end
endfunction

// Returns 1 when the home has to answer and sets the expected message kind
function automatic logic predict_request(input req_tx_t tx, input line_addr_t addr,
                                         output resp_kind_t kind);
  logic respond;
  respond = 1'b0;
  kind    = DATA;
  case (model_state[addr])
    I: begin
      if (tx == PUTM) begin
        model_state[addr] = ID;
      end else begin
        respond           = 1'b1;
        kind              = (tx == GETS) ? EXCLUSIVE : DATA;
        model_state[addr] = EORMRD;
      end
    end
    S: begin
      if (tx == PUTM) begin
        model_state[addr] = SD;
      end else begin
        respond           = 1'b1;
        model_state[addr] = (tx == GETS) ? SRD : EORMRD;
      end
    end
    EORM: begin
      if (tx == GETS) begin
        model_state[addr] = SD;
      end else if (tx == PUTM) begin
        model_state[addr] = EORMD;
      end
    end
    default: begin
    end
  endcase
  return respond;
endfunction

// Home saw its own message on the bus
function automatic void commit_own_message(input line_addr_t addr);
  if (model_state[addr] == SRD) begin
    model_state[addr] = S;
  end else if (model_state[addr] == EORMRD) begin
    model_state[addr] = EORM;
  end
endfunction

// A peer message on the response bus
function automatic void apply_peer_message(input resp_kind_t kind, input logic mem_flag,
                                           input line_addr_t addr, input line_t data);
  logic write_back;
  write_back = mem_flag && (kind == DATA);
  case (model_state[addr])
    ID, SD: begin
      if (write_back) begin
        model_data[addr] = data;
      end
      if (write_back || kind == NODATA || kind == NODATAE) begin
        model_state[addr] = (model_state[addr] == ID) ? I : S;
      end
    end
    EORMD: begin
      if (write_back) begin
        model_data[addr]  = data;
        model_state[addr] = I;
      end else if (kind == NODATA) begin
        model_state[addr] = EORM;
      end else if (kind == NODATAE) begin
        model_state[addr] = I;
      end
    end
    default: begin
    end
  endcase
endfunction

`endif

/* sim/llc_home_tb.sv */
`default_nettype none

module llc_home_tb
  import bus_pkg::*, llc_pkg::*;
();

  localparam int TIMEOUT = 20;

  logic       clk;
  logic       rst;
  logic       req_valid;
  req_tx_t    req_tx;
  node_id_t   req_source;
  line_addr_t req_addr;
  logic       peer_req;
  node_id_t   peer_source;
  node_id_t   peer_dest;
  logic       peer_mem_flag;
  resp_kind_t peer_kind;
  line_addr_t peer_addr;
  line_t      peer_data;
  logic       peer_gnt;
  logic       resp_valid;
  node_id_t   resp_source;
  node_id_t   resp_dest;
  logic       resp_mem_flag;
  resp_kind_t resp_kind;
  line_addr_t resp_addr;
  line_t      resp_data;

  int         error_count = 0;
  int         test_start_errors = 0;
  int         tests_run = 0;
  int         tests_failed = 0;
  line_addr_t base;

  `include "llc_home_model.svh"

  llc_home_top u_llc_home_top (.*);

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  // The peer may only be granted while it asks for the bus
  always @(negedge clk) begin
    if (!rst) begin
      assert (!(peer_gnt && !peer_req)) else begin
        $display("Peer was granted at %0t while it was not requesting", $time);
        error_count++;
      end
    end
  end

  task automatic check_field(input string name, input logic [63:0] got,
                             input logic [63:0] exp);
    assert (got === exp) else begin
      $display("[ERROR] %0t %s: got %h, expected %h", $time, name, got, exp);
      error_count++;
    end
  endtask

  function automatic node_id_t pick_source();
    return node_id_t'($urandom_range(2, 0));
  endfunction

  // Next requester that is not the home
  function automatic node_id_t other_node(input node_id_t n);
    return (n == 2'd2) ? 2'd0 : node_id_t'(n + 1);
  endfunction

  function automatic line_addr_t line_at(input int k);
    return line_addr_t'(base + k);
  endfunction

  task automatic wait_home_msg(input node_id_t dest, input resp_kind_t kind,
                               input line_addr_t addr, input line_t data);
    int   cycles;
    logic found;
    cycles = 0;
    found  = 1'b0;
    while (!found && cycles < TIMEOUT) begin
      @(negedge clk);
      cycles++;
      if (resp_valid && resp_source == HOME_ID) begin
        found = 1'b1;
        check_field("resp_dest", resp_dest, dest);
        check_field("resp_kind", resp_kind, kind);
        check_field("resp_addr", resp_addr, addr);
        check_field("resp_data", resp_data, data);
        commit_own_message(addr);
      end
    end
    assert (found) else begin
      $display("Timed out waiting for the home response on line %0h", addr);
      error_count++;
    end
  endtask

  task automatic expect_silence(input line_addr_t addr);
    logic seen;
    seen = 1'b0;
    repeat (TIMEOUT) begin
      @(negedge clk);
      if (resp_valid && resp_source == HOME_ID) begin
        seen = 1'b1;
      end
    end
    assert (!seen) else begin
      $display("Home answered a request on line %0h that needs no answer", addr);
      error_count++;
    end
  endtask

  // One request on the bus followed by the home answer that the model predicts
  task automatic home_transaction(input req_tx_t tx, input node_id_t src,
                                  input line_addr_t addr);
    logic       respond;
    resp_kind_t kind;
    line_t      data;
    data    = model_data[addr];
    respond = predict_request(tx, addr, kind);
    @(posedge clk);
    req_valid  <= 1'b1;
    req_tx     <= tx;
    req_source <= src;
    req_addr   <= addr;
    @(posedge clk);
    req_valid <= 1'b0;
    if (respond) begin
      wait_home_msg(src, kind, addr, data);
    end else begin
      expect_silence(addr);
    end
  endtask

  task automatic send_peer(input node_id_t src, input node_id_t dest, input logic mem_flag,
                           input resp_kind_t kind, input line_addr_t addr, input line_t data);
    int   cycles;
    logic granted;
    cycles  = 0;
    granted = 1'b0;
    @(posedge clk);
    peer_req      <= 1'b1;
    peer_source   <= src;
    peer_dest     <= dest;
    peer_mem_flag <= mem_flag;
    peer_kind     <= kind;
    peer_addr     <= addr;
    peer_data     <= data;
    while (!granted && cycles < TIMEOUT) begin
      @(negedge clk);
      cycles++;
      if (peer_gnt) begin
        granted = 1'b1;
        check_field("resp_source", resp_source, src);
        check_field("resp_dest", resp_dest, dest);
        check_field("resp_mem_flag", resp_mem_flag, mem_flag);
        check_field("resp_kind", resp_kind, kind);
        check_field("resp_addr", resp_addr, addr);
        check_field("resp_data", resp_data, data);
        apply_peer_message(kind, mem_flag, addr, data);
      end
    end
    assert (granted) else begin
      $display("Timed out waiting for the peer grant on line %0h", addr);
      error_count++;
    end
    @(posedge clk);
    peer_req <= 1'b0;
  endtask

  // Home response and three peer messages compete from the same cycle
  task automatic run_contention(input line_addr_t home_line, input line_addr_t peer_line);
    node_id_t   src;
    resp_kind_t kind;
    line_t      hdata;
    logic       home_wait;
    logic       home_seen;
    logic       contended;
    logic       prev_contended;
    logic       prev_home_won;
    logic       peer_won;
    int         pidx;
    int         cycles;
    int         alternations;
    node_id_t   psrc [3];
    node_id_t   pdest [3];
    logic       pflag [3];
    resp_kind_t pkind [3];
    line_t      pdata [3];
    src   = pick_source();
    hdata = model_data[home_line];
    for (int k = 0; k < 3; k++) begin
      psrc[k]  = pick_source();
      pdest[k] = node_id_t'($urandom);
      pflag[k] = 1'($urandom);
      pkind[k] = resp_kind_t'($urandom_range(3, 0));
      pdata[k] = {$urandom, $urandom};
    end
    home_wait      = predict_request(GETS, home_line, kind);
    home_seen      = 1'b0;
    prev_contended = 1'b0;
    prev_home_won  = 1'b0;
    pidx           = 0;
    cycles         = 0;
    alternations   = 0;
    @(posedge clk);
    req_valid  <= 1'b1;
    req_tx     <= GETS;
    req_source <= src;
    req_addr   <= home_line;
    @(posedge clk);
    req_valid     <= 1'b0;
    peer_req      <= 1'b1;
    peer_source   <= psrc[0];
    peer_dest     <= pdest[0];
    peer_mem_flag <= pflag[0];
    peer_kind     <= pkind[0];
    peer_addr     <= peer_line;
    peer_data     <= pdata[0];
    while ((pidx < 3 || !home_seen) && cycles < TIMEOUT) begin
      @(negedge clk);
      cycles++;
      contended = home_wait && peer_req;
      peer_won  = 1'b0;
      if (resp_valid && resp_source == HOME_ID) begin
        assert (!home_seen) else begin
          $display("Home response appeared twice on the bus");
          error_count++;
        end
        check_field("resp_dest", resp_dest, src);
        check_field("resp_kind", resp_kind, kind);
        check_field("resp_addr", resp_addr, home_line);
        check_field("resp_data", resp_data, hdata);
        commit_own_message(home_line);
        if (contended && prev_contended) begin
          alternations++;
        end
        home_seen     = 1'b1;
        home_wait     = 1'b0;
        prev_home_won = 1'b1;
      end else if (resp_valid) begin
        check_field("peer_gnt", peer_gnt, 1'b1);
        check_field("resp_source", resp_source, psrc[pidx]);
        check_field("resp_dest", resp_dest, pdest[pidx]);
        check_field("resp_mem_flag", resp_mem_flag, pflag[pidx]);
        check_field("resp_kind", resp_kind, pkind[pidx]);
        check_field("resp_addr", resp_addr, peer_line);
        check_field("resp_data", resp_data, pdata[pidx]);
        apply_peer_message(pkind[pidx], pflag[pidx], peer_line, pdata[pidx]);
        if (contended && prev_contended) begin
          assert (prev_home_won) else begin
            $display("Peer won twice in a row under contention");
            error_count++;
          end
          alternations++;
        end
        peer_won      = 1'b1;
        prev_home_won = 1'b0;
      end else if (contended) begin
        $display("No grant at %0t while both requesters were waiting", $time);
        error_count++;
      end
      prev_contended = contended;
      @(posedge clk);
      if (peer_won) begin
        pidx++;
        if (pidx < 3) begin
          peer_source   <= psrc[pidx];
          peer_dest     <= pdest[pidx];
          peer_mem_flag <= pflag[pidx];
          peer_kind     <= pkind[pidx];
          peer_data     <= pdata[pidx];
        end else begin
          peer_req <= 1'b0;
        end
      end
    end
    peer_req <= 1'b0;
    assert (pidx == 3 && home_seen) else begin
      $display("Timed out before all contending messages reached the bus");
      error_count++;
    end
    assert (alternations > 0) else begin
      $display("Grants never alternated under contention");
      error_count++;
    end
  endtask

  task automatic end_test(input string name);
    tests_run++;
    if (error_count == test_start_errors) begin
      $display("Test %0d %s: ok", tests_run, name);
    end else begin
      tests_failed++;
      $display("Test %0d %s: %0d errors", tests_run, name, error_count - test_start_errors);
    end
    test_start_errors = error_count;
  endtask

  initial begin
    node_id_t a_src;
    node_id_t b_src;
    line_t    wb;
    void'($urandom(32'hc1f9));
    rst           = 1'b1;
    req_valid     = 1'b0;
    req_tx        = GETS;
    req_source    = '0;
    req_addr      = '0;
    peer_req      = 1'b0;
    peer_source   = '0;
    peer_dest     = '0;
    peer_mem_flag = 1'b0;
    peer_kind     = DATA;
    peer_addr     = '0;
    peer_data     = '0;
    clear_lines();
    repeat (4) @(posedge clk);
    rst <= 1'b0;
    @(negedge clk);
    check_field("resp_valid", resp_valid, 1'b0);
    check_field("peer_gnt", peer_gnt, 1'b0);

    base  = line_addr_t'($urandom);
    a_src = pick_source();
    b_src = other_node(a_src);

    home_transaction(GETS, a_src, line_at(0));
    home_transaction(GETS, b_src, line_at(0));
    end_test("GetS on an invalid line");

    home_transaction(GETS, a_src, line_at(1));
    home_transaction(GETS, b_src, line_at(1));
    wb = {$urandom, $urandom};
    send_peer(a_src, b_src, 1'b1, DATA, line_at(1), wb);
    home_transaction(GETS, other_node(b_src), line_at(1));
    end_test("Ownership transfer");

    // Bring the line to S first
    home_transaction(GETS, a_src, line_at(2));
    home_transaction(GETS, b_src, line_at(2));
    send_peer(a_src, b_src, 1'b0, NODATA, line_at(2), {$urandom, $urandom});
    home_transaction(GETM, b_src, line_at(2));
    home_transaction(GETM, a_src, line_at(2));
    end_test("GetM on a shared line");

    home_transaction(GETM, a_src, line_at(3));
    home_transaction(PUTM, a_src, line_at(3));
    send_peer(a_src, HOME_ID, 1'b1, DATA, line_at(3), {$urandom, $urandom});
    home_transaction(GETS, b_src, line_at(3));
    home_transaction(GETM, a_src, line_at(4));
    home_transaction(PUTM, a_src, line_at(4));
    send_peer(a_src, HOME_ID, 1'b0, NODATA, line_at(4), {$urandom, $urandom});
    home_transaction(GETS, b_src, line_at(4));
    send_peer(a_src, b_src, 1'b0, NODATA, line_at(4), {$urandom, $urandom});
    home_transaction(GETS, other_node(b_src), line_at(4));
    home_transaction(GETM, a_src, line_at(5));
    home_transaction(PUTM, a_src, line_at(5));
    send_peer(a_src, HOME_ID, 1'b0, NODATAE, line_at(5), {$urandom, $urandom});
    home_transaction(GETS, b_src, line_at(5));
    end_test("PutM write-back");

    // An uncontended home grant first lets the peer win the first tie
    home_transaction(GETS, a_src, line_at(8));
    run_contention(line_at(6), line_at(7));
    end_test("Response bus arbitration");

    $display("Tests run: %0d, failed: %0d, errors: %0d", tests_run, tests_failed, error_count);
    if (error_count == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* compile.f */
+incdir+sim
rtl/bus_pkg.sv
rtl/llc_pkg.sv
rtl/llc_line_store.sv
rtl/resp_bus_arbiter.sv
rtl/llc_coherence.sv
rtl/llc_home_top.sv
sim/llc_home_tb.sv

/* Bender.yml */
package:
  name: llc_home

sources:
  - rtl/bus_pkg.sv
  - rtl/llc_pkg.sv
  - rtl/llc_line_store.sv
  - rtl/resp_bus_arbiter.sv
  - rtl/llc_coherence.sv
  - rtl/llc_home_top.sv
  - target: simulation
    include_dirs:
      - sim
    files:
      - sim/llc_home_tb.sv
